/* bench/tb_clk_gen.sv */
// testbench clock and reset source
// 4 ns reference clock, board reset held low for the first 4 cycles

`timescale 1ns/1ns

module tb_clk_gen (
  output logic clk_o,
  output logic arst_n_o
);

  // half of the 4 ns period
  localparam int unsigned HALF_PERIOD  = 2;
  // rising edges with reset held low
  localparam int unsigned RESET_CYCLES = 4;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  initial begin
    arst_n_o <= 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    // released on an edge, synchronizer starts on the next one
    arst_n_o <= 1'b1;
  end

endmodule

/* bench/tb_safe_domain.sv */
// safe domain testbench
// directed tests of reset release, slow clock, pad routing and wake-up

`timescale 1ns/1ns

module tb_safe_domain;

  localparam int unsigned N_IO           = pad_pkg::N_IO_DEFAULT;
  localparam int unsigned SLOW_CLK_DIV   = 8;
  // rst_n_o rises at this edge after release
  localparam int unsigned RST_EDGES      = 2;
  // wake_o rises at this edge after the input edge
  localparam int unsigned WAKE_EDGES     = 3;
  // enabled wake pad, and one left disabled
  localparam int unsigned WAKE_PAD       = 3;
  localparam int unsigned QUIET_PAD      = 9;
  // all tests take a few hundred cycles
  localparam int unsigned TIMEOUT_CYCLES = 2000;

  // ********************
  // DUT signals
  // ********************

  logic ref_clk_i;
  logic arst_n_i;
  logic slow_clk_o;
  logic rst_n_o;
  pad_pkg::padmux_t [N_IO-1:0] pad_mux_i;
  pad_pkg::padcfg_t [N_IO-1:0] pad_cfg_i;
  pad_pkg::padcfg_t [N_IO-1:0] pad_cfg_o;
  logic [N_IO-1:0] io_in_i;
  logic [N_IO-1:0] io_out_o;
  logic [N_IO-1:0] io_oe_o;
  logic [N_IO-1:0] gpio_out_i;
  logic [N_IO-1:0] gpio_oe_i;
  logic [N_IO-1:0] gpio_in_o;
  logic [N_IO-1:0] perio_out_i;
  logic [N_IO-1:0] perio_oe_i;
  logic [N_IO-1:0] perio_in_o;
  logic [N_IO-1:0] fpgaio_out_i;
  logic [N_IO-1:0] fpgaio_oe_i;
  logic [N_IO-1:0] fpgaio_in_o;
  logic [N_IO-1:0] wake_en_i;
  logic wake_clr_i;
  logic wake_o;

  // run bookkeeping
  int          err_cnt   = 0;
  int          cycle_cnt = 0;
  logic [31:0] rng       = 32'hd9d1_19e5;

  tb_clk_gen i_clk_gen (
    .clk_o    ( ref_clk_i ),
    .arst_n_o ( arst_n_i  )
  );

  safe_domain #(
    .N_IO         ( N_IO         ),
    .SLOW_CLK_DIV ( SLOW_CLK_DIV )
  ) DUT (
    .*
  );

  // ********************
  // helpers
  // ********************

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  task automatic report_error(input string msg);
    err_cnt++;
    $display("error at %0t ns: %s", $time, msg);
  endtask

  task automatic init_inputs();
    pad_mux_i    <= {N_IO{pad_pkg::PADMUX_OFF}};
    pad_cfg_i    <= '0;
    io_in_i      <= '0;
    gpio_out_i   <= '0;
    gpio_oe_i    <= '0;
    perio_out_i  <= '0;
    perio_oe_i   <= '0;
    fpgaio_out_i <= '0;
    fpgaio_oe_i  <= '0;
    wake_en_i    <= '0;
    wake_clr_i   <= 1'b0;
  endtask

  // wake_o must stay low for n cycles
  task automatic expect_wake_low(input int n, input string what);
    for (int i = 0; i < n; i++) begin
      @(negedge ref_clk_i);
      if (wake_o !== 1'b0) begin
        report_error($sformatf("wake_o high after %s", what));
      end
    end
  endtask

  // ********************
  // tests
  // ********************

  task automatic reset_release();
    int edges = 0;
    @(negedge ref_clk_i);
    while (arst_n_i !== 1'b1) begin
      if (rst_n_o !== 1'b0 || slow_clk_o !== 1'b0 || wake_o !== 1'b0) begin
        report_error($sformatf("in reset rst_n_o %b slow_clk_o %b wake_o %b",
                               rst_n_o, slow_clk_o, wake_o));
      end
      @(negedge ref_clk_i);
    end
    // count edges from release to rst_n_o high
    while (rst_n_o !== 1'b1 && edges < 8) begin
      @(posedge ref_clk_i);
      edges++;
      @(negedge ref_clk_i);
    end
    if (edges != RST_EDGES) begin
      report_error($sformatf("rst_n_o rose after %0d edges, expected %0d", edges, RST_EDGES));
    end
  endtask

  // spacing of three rising edges, sampled on the falling reference edge
  task automatic slow_clock_period();
    int   cyc       = 0;
    int   last_rise = 0;
    int   rises     = 0;
    int   high_cnt  = 0;
    logic prev;
    prev = slow_clk_o;
    while (rises < 3 && cyc < 5 * SLOW_CLK_DIV) begin
      @(negedge ref_clk_i);
      cyc++;
      if (slow_clk_o === 1'b1 && prev === 1'b0) begin
        if (rises > 0 && (cyc - last_rise != SLOW_CLK_DIV || high_cnt != SLOW_CLK_DIV / 2)) begin
          report_error($sformatf("slow_clk_o period %0d high %0d, expected %0d and %0d",
                                 cyc - last_rise, high_cnt, SLOW_CLK_DIV, SLOW_CLK_DIV / 2));
        end
        rises++;
        last_rise = cyc;
        high_cnt  = 0;
      end
      if (slow_clk_o === 1'b1) begin
        high_cnt++;
      end
      prev = slow_clk_o;
    end
    if (rises < 3) begin
      report_error($sformatf("slow_clk_o rose only %0d times in %0d cycles", rises, cyc));
    end
  endtask

  task automatic pad_output_routing(input int n_vec);
    logic [31:0]                 r;
    pad_pkg::padmux_t [N_IO-1:0] mux_v;
    pad_pkg::padcfg_t [N_IO-1:0] cfg_v;
    pad_pkg::padcfg_t [N_IO-1:0] exp_cfg;
    // user values indexed by mux code
    logic [2:0][N_IO-1:0]        out_v;
    logic [2:0][N_IO-1:0]        oe_v;
    logic [N_IO-1:0]             exp_out;
    logic [N_IO-1:0]             exp_oe;
    @(posedge ref_clk_i);
    for (int v = 0; v < n_vec; v++) begin
      for (int k = 0; k < N_IO; k++) begin
        rng = xorshift32(rng);
        r = rng;
        mux_v[k] = r[1:0];
        cfg_v[k] = r[7:2];
        out_v[pad_pkg::PADMUX_GPIO][k]   = r[8];
        oe_v[pad_pkg::PADMUX_GPIO][k]    = r[9];
        out_v[pad_pkg::PADMUX_PERIO][k]  = r[10];
        oe_v[pad_pkg::PADMUX_PERIO][k]   = r[11];
        out_v[pad_pkg::PADMUX_FPGAIO][k] = r[12];
        oe_v[pad_pkg::PADMUX_FPGAIO][k]  = r[13];
        // parked pad drives nothing and loses its config
        exp_out[k] = 1'b0;
        exp_oe[k]  = 1'b0;
        exp_cfg[k] = '0;
        if (mux_v[k] != pad_pkg::PADMUX_OFF) begin
          exp_out[k] = out_v[mux_v[k]][k];
          exp_oe[k]  = oe_v[mux_v[k]][k];
          exp_cfg[k] = cfg_v[k];
        end
      end
      pad_mux_i    <= mux_v;
      pad_cfg_i    <= cfg_v;
      gpio_out_i   <= out_v[pad_pkg::PADMUX_GPIO];
      gpio_oe_i    <= oe_v[pad_pkg::PADMUX_GPIO];
      perio_out_i  <= out_v[pad_pkg::PADMUX_PERIO];
      perio_oe_i   <= oe_v[pad_pkg::PADMUX_PERIO];
      fpgaio_out_i <= out_v[pad_pkg::PADMUX_FPGAIO];
      fpgaio_oe_i  <= oe_v[pad_pkg::PADMUX_FPGAIO];
      // combinational, checked one cycle later
      @(posedge ref_clk_i);
      if (io_out_o !== exp_out || io_oe_o !== exp_oe) begin
        report_error($sformatf("vector %0d io_out_o %h io_oe_o %h, expected %h %h",
                               v, io_out_o, io_oe_o, exp_out, exp_oe));
      end
      if (pad_cfg_o !== exp_cfg) begin
        report_error($sformatf("vector %0d pad_cfg_o %h, expected %h", v, pad_cfg_o, exp_cfg));
      end
    end
  endtask

  task automatic pad_input_routing(input int n_vec);
    logic [31:0]                 r;
    pad_pkg::padmux_t [N_IO-1:0] mux_v;
    logic [N_IO-1:0]             io_v;
    // expected user inputs indexed by mux code
    logic [2:0][N_IO-1:0]        exp_in;
    @(posedge ref_clk_i);
    for (int v = 0; v < n_vec; v++) begin
      exp_in = '0;
      for (int k = 0; k < N_IO; k++) begin
        rng = xorshift32(rng);
        r = rng;
        mux_v[k] = r[1:0];
        io_v[k]  = r[2];
        if (mux_v[k] != pad_pkg::PADMUX_OFF) begin
          exp_in[mux_v[k]][k] = io_v[k];
        end
      end
      pad_mux_i <= mux_v;
      io_in_i   <= io_v;
      @(posedge ref_clk_i);
      if (gpio_in_o !== exp_in[pad_pkg::PADMUX_GPIO]
          || perio_in_o !== exp_in[pad_pkg::PADMUX_PERIO]
          || fpgaio_in_o !== exp_in[pad_pkg::PADMUX_FPGAIO]) begin
        report_error($sformatf("vector %0d user inputs %h %h %h, expected %h", v,
                               gpio_in_o, perio_in_o, fpgaio_in_o, exp_in));
      end
    end
  endtask

  task automatic wake_detection();
    logic [N_IO-1:0] en_v;
    int              edges = 0;
    en_v = '0;
    en_v[WAKE_PAD] = 1'b1;
    // all pads to gpio, inputs low, synchronizer left to settle
    @(posedge ref_clk_i);
    pad_mux_i <= {N_IO{pad_pkg::PADMUX_GPIO}};
    io_in_i   <= '0;
    repeat (4) @(posedge ref_clk_i);
    // one pad enabled, edge on a disabled one
    wake_en_i          <= en_v;
    io_in_i[QUIET_PAD] <= 1'b1;
    expect_wake_low(6, "edge on a disabled pad");
    // enabled pad handed to the peripheral user
    @(posedge ref_clk_i);
    pad_mux_i[WAKE_PAD] <= pad_pkg::PADMUX_PERIO;
    io_in_i[WAKE_PAD]   <= 1'b1;
    expect_wake_low(6, "edge on a pad routed away from gpio");
    @(posedge ref_clk_i);
    io_in_i[WAKE_PAD]   <= 1'b0;
    pad_mux_i[WAKE_PAD] <= pad_pkg::PADMUX_GPIO;
    repeat (4) @(posedge ref_clk_i);
    // enabled edge, counted until the flag shows
    io_in_i[WAKE_PAD] <= 1'b1;
    @(negedge ref_clk_i);
    while (wake_o !== 1'b1 && edges < 10) begin
      @(posedge ref_clk_i);
      edges++;
      @(negedge ref_clk_i);
    end
    if (edges != WAKE_EDGES) begin
      report_error($sformatf("wake_o rose after %0d edges, expected %0d", edges, WAKE_EDGES));
    end
    // sticky until cleared
    for (int i = 0; i < 5; i++) begin
      @(negedge ref_clk_i);
      if (wake_o !== 1'b1) begin
        report_error("wake_o dropped before wake_clr_i");
      end
    end
    @(posedge ref_clk_i);
    wake_clr_i <= 1'b1;
    @(posedge ref_clk_i);
    wake_clr_i <= 1'b0;
    expect_wake_low(5, "wake_clr_i");
  endtask

  // ********************
  // run control
  // ********************

  always @(posedge ref_clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: tests still running after %0d reference cycles", TIMEOUT_CYCLES);
      $display("Test failures found");
      $finish;
    end
  end

  initial begin
    init_inputs();
    reset_release();
    slow_clock_period();
    pad_output_routing(40);
    pad_input_routing(40);
    wake_detection();
    $display("done after %0d cycles, %0d errors", cycle_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* common/clk_rst_pkg.sv */
// clock and reset definitions
// synchronizer depth and clock divider counter type

package clk_rst_pkg;

  // ********************
  // synchronizers
  // ********************

  // flop count of every synchronizer chain
  // two stages, enough for the reference clock rate
  localparam int unsigned SYNC_STAGES = 2;

  // ********************
  // clock divider
  // ********************

  // half-period counter of the slow clock divider
  // covers division ratios up to 256
  typedef logic [7:0] div_cnt_t;

endpackage

/* common/pad_pkg.sv */
// pad multiplexing definitions
// routing codes for the pad users and the pad configuration word

package pad_pkg;

  // ********************
  // pad function select
  // ********************

  // 2-bit select per pad
  typedef logic [1:0] padmux_t;

  // pad owned by the gpio block
  localparam padmux_t PADMUX_GPIO   = 2'd0;
  // pad owned by the peripheral io
  localparam padmux_t PADMUX_PERIO  = 2'd1;
  // pad owned by the fpga-side io
  localparam padmux_t PADMUX_FPGAIO = 2'd2;
  // pad parked, nothing driven or read
  localparam padmux_t PADMUX_OFF    = 2'd3;

  // ********************
  // pad electrical config
  // ********************

  // pull, drive strength and slew bits, passed through to the pad cell
  typedef logic [5:0] padcfg_t;

  // pad count used unless the top level says otherwise
  localparam int unsigned N_IO_DEFAULT = 16;

endpackage

/* filelist.f */
common/pad_pkg.sv
common/clk_rst_pkg.sv
source/rst_sync.sv
source/slow_clk_gen.sv
pad_control/pad_control.sv
source/gpio_wake.sv
source/safe_domain.sv
bench/tb_clk_gen.sv
bench/tb_safe_domain.sv

/* pad_control/pad_control.sv */
// pad control
// routes each pad to the gpio, peripheral or fpga-side user, or parks it

`timescale 1ns/1ns

module pad_control #(
  parameter int unsigned N_IO = pad_pkg::N_IO_DEFAULT
) (
  // per-pad function select and config
  input  pad_pkg::padmux_t [N_IO-1:0] pad_mux_i,
  input  pad_pkg::padcfg_t [N_IO-1:0] pad_cfg_i,
  output pad_pkg::padcfg_t [N_IO-1:0] pad_cfg_o,

  // pad side
  input  logic [N_IO-1:0] io_in_i,
  output logic [N_IO-1:0] io_out_o,
  output logic [N_IO-1:0] io_oe_o,

  // gpio user
  input  logic [N_IO-1:0] gpio_out_i,
  input  logic [N_IO-1:0] gpio_oe_i,
  output logic [N_IO-1:0] gpio_in_o,

  // peripheral user
  input  logic [N_IO-1:0] perio_out_i,
  input  logic [N_IO-1:0] perio_oe_i,
  output logic [N_IO-1:0] perio_in_o,

  // fpga-side user
  input  logic [N_IO-1:0] fpgaio_out_i,
  input  logic [N_IO-1:0] fpgaio_oe_i,
  output logic [N_IO-1:0] fpgaio_in_o
);

  // ********************
  // per-pad routing
  // ********************

  for (genvar k = 0; k < N_IO; k++) begin : gen_pad
    // selected output and enable
    logic out_sel;
    logic oe_sel;
    // input fanned back to one user only
    logic gpio_in_sel;
    logic perio_in_sel;
    logic fpgaio_in_sel;
    // pad not parked
    logic pad_used;

    always_comb begin
      // parked values, overridden by the owning user
      out_sel       = 1'b0;
      oe_sel        = 1'b0;
      gpio_in_sel   = 1'b0;
      perio_in_sel  = 1'b0;
      fpgaio_in_sel = 1'b0;
      case (pad_mux_i[k])
        pad_pkg::PADMUX_GPIO: begin
          out_sel     = gpio_out_i[k];
          oe_sel      = gpio_oe_i[k];
          gpio_in_sel = io_in_i[k];
        end
        pad_pkg::PADMUX_PERIO: begin
          out_sel      = perio_out_i[k];
          oe_sel       = perio_oe_i[k];
          perio_in_sel = io_in_i[k];
        end
        pad_pkg::PADMUX_FPGAIO: begin
          out_sel       = fpgaio_out_i[k];
          oe_sel        = fpgaio_oe_i[k];
          fpgaio_in_sel = io_in_i[k];
        end
        default: begin
          // PADMUX_OFF, driver off and every user reads 0
          out_sel = 1'b0;
          oe_sel  = 1'b0;
        end
      endcase
    end

    assign pad_used = (pad_mux_i[k] != pad_pkg::PADMUX_OFF);

    // pad side
    assign io_out_o[k] = out_sel;
    assign io_oe_o[k]  = oe_sel;

    // user side
    assign gpio_in_o[k]   = gpio_in_sel;
    assign perio_in_o[k]  = perio_in_sel;
    assign fpgaio_in_o[k] = fpgaio_in_sel;

    // config word zeroed on parked pads
    assign pad_cfg_o[k] = pad_used ? pad_cfg_i[k] : '0;
  end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the safe domain testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -j 0 \
  --top-module tb_safe_domain \
  -f filelist.f \
  --Mdir "$BUILD_DIR" -o tb_safe_domain

"./$BUILD_DIR/tb_safe_domain" | tee "$LOG"

if grep -qxF 'All tests passed!' "$LOG"; then
  echo "simulation passed"
else
  echo "simulation failed, see $LOG"
  exit 1
fi

/* source/gpio_wake.sv */
// gpio wake-up detector
// sticky flag set by a rising edge on an enabled gpio input

`timescale 1ns/1ns

module gpio_wake #(
  parameter int unsigned N_IO = pad_pkg::N_IO_DEFAULT
) (
  input  logic            ref_clk_i,
  input  logic            rst_n_i,
  // routed gpio inputs, asynchronous to ref_clk_i
  input  logic [N_IO-1:0] gpio_in_i,
  // per-pad wake enable
  input  logic [N_IO-1:0] wake_en_i,
  // clears the flag, wins over a new edge
  input  logic            wake_clr_i,
  output logic            wake_o
);

  // synchronizer stages, index 0 first
  logic [clk_rst_pkg::SYNC_STAGES-1:0][N_IO-1:0] sync_q;
  // previous synchronized value
  logic [N_IO-1:0]                               prev_q;
  // synchronized value, last stage
  logic [N_IO-1:0]                               gpio_sync;
  // enabled rising edges this cycle
  logic [N_IO-1:0]                               rise;
  // sticky wake flag
  logic                                          wake_q;

  // ********************
  // input synchronizer
  // ********************

  always_ff @(posedge ref_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_q <= '0;
      prev_q <= '0;
    end else begin
      // shift in the raw pad bits
      sync_q <= {sync_q[clk_rst_pkg::SYNC_STAGES-2:0], gpio_in_i};
      // one cycle behind for edge detection
      prev_q <= gpio_sync;
    end
  end

  assign gpio_sync = sync_q[clk_rst_pkg::SYNC_STAGES-1];

  // ********************
  // edge detect and flag
  // ********************

  // low to high, masked per pad
  assign rise = gpio_sync & ~prev_q & wake_en_i;

  always_ff @(posedge ref_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wake_q <= 1'b0;
    end else if (wake_clr_i) begin
      // clear first, an edge in the same cycle is dropped
      wake_q <= 1'b0;
    end else if (|rise) begin
      wake_q <= 1'b1;
    end
  end

  assign wake_o = wake_q;

endmodule

/* source/rst_sync.sv */
// reset synchronizer
// asynchronous assert, release aligned to the reference clock

`timescale 1ns/1ns

module rst_sync (
  input  logic ref_clk_i,
  input  logic arst_n_i,
  output logic rst_n_o
);

  // chain of ones shifted in after release
  logic [clk_rst_pkg::SYNC_STAGES-1:0] sync_q;

  // ********************
  // release chain
  // ********************

  always_ff @(posedge ref_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      // assert at once, no clock needed
      sync_q <= '0;
    end else begin
      // one more stage released per edge
      sync_q <= {sync_q[clk_rst_pkg::SYNC_STAGES-2:0], 1'b1};
    end
  end

  // last stage is the synchronized reset
  // rises at the SYNC_STAGES-th edge after release
  assign rst_n_o = sync_q[clk_rst_pkg::SYNC_STAGES-1];

endmodule

/* source/safe_domain.sv */
// always-on safe domain
// reset sync, slow clock, pad routing and gpio wake-up

`timescale 1ns/1ns

module safe_domain #(
  parameter int unsigned N_IO         = pad_pkg::N_IO_DEFAULT,
  // even, 2 to 256
  parameter int unsigned SLOW_CLK_DIV = 8
) (
  // board clock and reset
  input  logic                        ref_clk_i,
  input  logic                        arst_n_i,
  output logic                        slow_clk_o,
  output logic                        rst_n_o,

  // pad control
  input  pad_pkg::padmux_t [N_IO-1:0] pad_mux_i,
  input  pad_pkg::padcfg_t [N_IO-1:0] pad_cfg_i,
  output pad_pkg::padcfg_t [N_IO-1:0] pad_cfg_o,

  // pads
  input  logic [N_IO-1:0]             io_in_i,
  output logic [N_IO-1:0]             io_out_o,
  output logic [N_IO-1:0]             io_oe_o,

  // gpio user
  input  logic [N_IO-1:0]             gpio_out_i,
  input  logic [N_IO-1:0]             gpio_oe_i,
  output logic [N_IO-1:0]             gpio_in_o,

  // peripheral user
  input  logic [N_IO-1:0]             perio_out_i,
  input  logic [N_IO-1:0]             perio_oe_i,
  output logic [N_IO-1:0]             perio_in_o,

  // fpga-side user
  input  logic [N_IO-1:0]             fpgaio_out_i,
  input  logic [N_IO-1:0]             fpgaio_oe_i,
  output logic [N_IO-1:0]             fpgaio_in_o,

  // wake-up
  input  logic [N_IO-1:0]             wake_en_i,
  input  logic                        wake_clr_i,
  output logic                        wake_o
);

  // reset released on ref_clk_i, used by all flops here
  logic            rst_n_sync;
  // routed gpio inputs, shared by the gpio user and the wake logic
  logic [N_IO-1:0] gpio_in;

  // ********************
  // clock and reset
  // ********************

  rst_sync i_rst_sync (
    .ref_clk_i ( ref_clk_i  ),
    .arst_n_i  ( arst_n_i   ),
    .rst_n_o   ( rst_n_sync )
  );

  slow_clk_gen #(
    .SLOW_CLK_DIV ( SLOW_CLK_DIV )
  ) i_slow_clk_gen (
    .ref_clk_i  ( ref_clk_i  ),
    .rst_n_i    ( rst_n_sync ),
    .slow_clk_o ( slow_clk_o )
  );

  assign rst_n_o = rst_n_sync;

  // ********************
  // pads
  // ********************

  pad_control #(
    .N_IO ( N_IO )
  ) i_pad_control (
    .pad_mux_i    ( pad_mux_i    ),
    .pad_cfg_i    ( pad_cfg_i    ),
    .pad_cfg_o    ( pad_cfg_o    ),
    .io_in_i      ( io_in_i      ),
    .io_out_o     ( io_out_o     ),
    .io_oe_o      ( io_oe_o      ),
    .gpio_out_i   ( gpio_out_i   ),
    .gpio_oe_i    ( gpio_oe_i    ),
    .gpio_in_o    ( gpio_in      ),
    .perio_out_i  ( perio_out_i  ),
    .perio_oe_i   ( perio_oe_i   ),
    .perio_in_o   ( perio_in_o   ),
    .fpgaio_out_i ( fpgaio_out_i ),
    .fpgaio_oe_i  ( fpgaio_oe_i  ),
    .fpgaio_in_o  ( fpgaio_in_o  )
  );

  assign gpio_in_o = gpio_in;

  // ********************
  // wake-up
  // ********************

  gpio_wake #(
    .N_IO ( N_IO )
  ) i_gpio_wake (
    .ref_clk_i  ( ref_clk_i  ),
    .rst_n_i    ( rst_n_sync ),
    .gpio_in_i  ( gpio_in    ),
    .wake_en_i  ( wake_en_i  ),
    .wake_clr_i ( wake_clr_i ),
    .wake_o     ( wake_o     )
  );

endmodule

/* source/slow_clk_gen.sv */
// slow clock generator
// even divider of the reference clock, 50% duty, starts low

`timescale 1ns/1ns

module slow_clk_gen #(
  // division ratio, even, 2 to 256
  parameter int unsigned SLOW_CLK_DIV = 8
) (
  input  logic ref_clk_i,
  input  logic rst_n_i,
  output logic slow_clk_o
);

  // last count value of a half period
  localparam clk_rst_pkg::div_cnt_t HALF_LAST =
    clk_rst_pkg::div_cnt_t'(SLOW_CLK_DIV / 2 - 1);

  // reference edges seen in the current half period
  clk_rst_pkg::div_cnt_t cnt_q;
  // divided clock flop
  logic                  slow_clk_q;
  // end of half period reached
  logic                  half_done;

  assign half_done = (cnt_q == HALF_LAST);

  // ********************
  // half period counter
  // ********************

  always_ff @(posedge ref_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cnt_q <= '0;
    end else if (half_done) begin
      // wrap, next half period starts
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // ********************
  // clock toggle
  // ********************

  always_ff @(posedge ref_clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      // low out of reset
      slow_clk_q <= 1'b0;
    end else if (half_done) begin
      // toggle every SLOW_CLK_DIV/2 edges
      slow_clk_q <= ~slow_clk_q;
    end
  end

  // straight from a flop, glitch-free
  assign slow_clk_o = slow_clk_q;

endmodule
